// ==== rtl/eg_pkg.sv ====
// shared ADSR phase encoding, slot configuration and stage structs for the envelope generator
package eg_pkg;

    ////////////////////////////////////////////////////////////
    // constants

    localparam int EG_CNT_W = 15;              // global frame counter width

    typedef logic [9:0] eg_level_t;            // attenuation, 0 loudest
    localparam eg_level_t EG_SILENT = 10'd1023;

    ////////////////////////////////////////////////////////////
    // per slot phase and configuration

    typedef enum logic [1:0] {
        EG_ATTACK  = 2'd0,
        EG_DECAY   = 2'd1,
        EG_SUSTAIN = 2'd2,
        EG_RELEASE = 2'd3                      // also the idle phase after reset
    } eg_phase_e;

    typedef struct packed {
        logic       keyon;
        logic       en_sus;                    // 0 gives a percussive envelope
        logic [3:0] arate;
        logic [3:0] drate;
        logic [3:0] rrate;
        logic [3:0] sl;                        // sustain level, x32 on the level scale
        logic [3:0] keycode;
        logic       ks;                        // full key scaling
        logic [5:0] tl;                        // total level, x4 on the level scale
        logic       amsen;
        logic       ams;                       // 1 selects full am depth
        logic [6:0] lfo_mod;
        logic       spare;
    } eg_slot_cfg_t;

    // stage II result handed to the level arithmetic
    typedef struct packed {
        logic       step;                      // level moves this frame
        logic       attack;
        logic [2:0] shift_inc;                 // log2 of increment
        logic       instant;                   // attack rate 15
        logic [3:0] spare;
    } eg_step_t;

endpackage

// ==== rtl/eg_frame_counter.sv ====
// global envelope counter, advances once per slot frame unless stopped
`timescale 1ns/1ps

module eg_frame_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        zero,     // slot 0 strobe
    input  logic                        eg_stop,  // freeze envelope time base
    output logic [eg_pkg::EG_CNT_W-1:0] eg_cnt
);

    logic frame_tick;

    // one tick per frame, on the slot 0 strobe
    assign frame_tick = cen & zero & ~eg_stop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eg_cnt <= '0;
        end else if (frame_tick) begin
            eg_cnt <= eg_cnt + 1'b1;  // wraps freely
        end
    end

endmodule

// ==== rtl/eg_slot_delay.sv ====
// per slot shift delay line, clock enabled, with a synchronous reset value
`timescale 1ns/1ps

module eg_slot_delay #(
    parameter int               WIDTH   = 1,
    parameter int               STAGES  = 18,
    parameter logic [WIDTH-1:0] RST_VAL = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] sr [STAGES];  // sr[0] newest slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sr[i] <= RST_VAL;
            end
        end else if (cen) begin
            sr[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                sr[i] <= sr[i-1];  // one slot per strobe
            end
        end
    end

    assign dout = sr[STAGES-1];  // oldest entry

endmodule

// ==== rtl/eg_phase_ctrl.sv ====
// stage I of the envelope, key edge detection, ADSR phase transition and base rate pick
`timescale 1ns/1ps

module eg_phase_ctrl (
    input  eg_pkg::eg_slot_cfg_t cfg,
    input  logic                 key_last,    // key seen one frame ago
    input  eg_pkg::eg_phase_e    phase_in,
    input  eg_pkg::eg_level_t    level_in,
    output eg_pkg::eg_phase_e    phase_next,
    output logic [3:0]           base_rate,
    output logic                 pg_rst
);

    import eg_pkg::*;

    logic      key_on_edge;
    logic      key_off_edge;
    eg_level_t sus_level;

    ////////////////////////////////////////////////////////////
    // key edges

    assign key_on_edge  =  cfg.keyon & ~key_last;
    assign key_off_edge = ~cfg.keyon &  key_last;
    assign sus_level    = {1'b0, cfg.sl, 5'd0};   // sl x 32
    assign pg_rst       = key_on_edge;             // restart phase accumulator

    ////////////////////////////////////////////////////////////
    // phase transition

    always_comb begin
        phase_next = phase_in;  // hold by default
        if (key_on_edge) begin
            phase_next = EG_ATTACK;
        end else if (key_off_edge) begin
            phase_next = EG_RELEASE;
        end else begin
            case (phase_in)
                EG_ATTACK: begin
                    if (level_in == '0) begin
                        phase_next = EG_DECAY;  // peak reached
                    end
                end
                EG_DECAY: begin
                    if (level_in >= sus_level) begin
                        // percussive mode keeps falling at release rate
                        phase_next = cfg.en_sus ? EG_SUSTAIN : EG_RELEASE;
                    end
                end
                default: begin
                    phase_next = phase_in;  // sustain and release only leave on keys
                end
            endcase
        end
    end

    // rate for the phase being entered
    always_comb begin
        case (phase_next)
            EG_ATTACK:  base_rate = cfg.arate;
            EG_DECAY:   base_rate = cfg.drate;
            EG_SUSTAIN: base_rate = 4'd0;       // level held
            default:    base_rate = cfg.rrate;
        endcase
    end

endmodule

// ==== rtl/eg_step_gen.sv ====
// stage II of the envelope, key scaled rate and step decision from the frame counter
`timescale 1ns/1ps

module eg_step_gen (
    input  logic [3:0]                  base_rate,
    input  logic                        attack,
    input  logic                        arate_max,  // arate == 15
    input  logic [3:0]                  keycode,
    input  logic                        ks,
    input  logic [eg_pkg::EG_CNT_W-1:0] eg_cnt,
    output eg_pkg::eg_step_t            step_info
);

    import eg_pkg::*;

    logic [6:0]          ks_term;
    logic [6:0]          rate_sum;
    logic [5:0]          rate;         // effective rate R, 0..63
    logic [3:0]          rate_hi;      // R / 4
    logic [3:0]          period_exp;
    logic [EG_CNT_W-1:0] period_mask;

    ////////////////////////////////////////////////////////////
    // effective rate

    always_comb begin
        ks_term  = ks ? {3'd0, keycode} : {5'd0, keycode[3:2]};
        rate_sum = {1'b0, base_rate, 2'b00} + ks_term;
        if (base_rate == 4'd0) begin
            rate = 6'd0;  // rate 0 never steps, no key scaling
        end else if (rate_sum > 7'd63) begin
            rate = 6'd63;
        end else begin
            rate = rate_sum[5:0];
        end
    end

    assign rate_hi = rate[5:2];

    ////////////////////////////////////////////////////////////
    // period test and increment

    always_comb begin
        // slow rates step every 2^(11 - R/4) frames, fast ones every frame
        period_exp  = (rate_hi >= 4'd11) ? 4'd0 : 4'd11 - rate_hi;
        period_mask = (EG_CNT_W'(1) << period_exp) - 1'b1;

        step_info.step      = (rate != 6'd0) && ((eg_cnt & period_mask) == '0);
        step_info.attack    = attack;
        // fast rates add 2^(R/4 - 11) per step
        step_info.shift_inc = (rate_hi > 4'd11) ? 3'(rate_hi - 4'd11) : 3'd0;
        step_info.instant   = attack & arate_max;
        step_info.spare     = '0;
    end

endmodule

// ==== rtl/eg_level_update.sv ====
// stage III of the envelope, attack and linear decay arithmetic on the level
`timescale 1ns/1ps

module eg_level_update (
    input  eg_pkg::eg_step_t  step_info,
    input  eg_pkg::eg_level_t level_in,
    output eg_pkg::eg_level_t level_out
);

    import eg_pkg::*;

    logic [14:0] atk_dec;  // up to 128 << 7
    logic [10:0] dec_sum;  // one carry bit for saturation

    ////////////////////////////////////////////////////////////
    // candidate results

    // attack slows down as the level approaches 0
    assign atk_dec = ({8'd0, level_in[9:3]} + 15'd1) << step_info.shift_inc;

    // decay, sustain and release climb linearly
    assign dec_sum = {1'b0, level_in} + (11'd1 << step_info.shift_inc);

    ////////////////////////////////////////////////////////////
    // select

    always_comb begin
        if (step_info.instant) begin
            level_out = '0;  // arate 15 jumps to full volume
        end else if (!step_info.step) begin
            level_out = level_in;
        end else if (step_info.attack) begin
            if (atk_dec >= {5'd0, level_in}) begin
                level_out = '0;  // floor at loudest
            end else begin
                level_out = level_in - atk_dec[9:0];
            end
        end else begin
            level_out = dec_sum[10] ? EG_SILENT : dec_sum[9:0];
        end
    end

endmodule

// ==== rtl/eg_output_mix.sv ====
// stage IV of the envelope, adds total level and am depth with saturation
`timescale 1ns/1ps

module eg_output_mix (
    input  eg_pkg::eg_level_t level,
    input  logic [5:0]        tl,
    input  logic              amsen,
    input  logic              ams,
    input  logic [6:0]        lfo_mod,
    output eg_pkg::eg_level_t eg_out
);

    import eg_pkg::*;

    logic [6:0]  am_term;
    logic [10:0] mix_sum;  // max 1023 + 252 + 127

    always_comb begin
        if (!amsen) begin
            am_term = 7'd0;
        end else if (ams) begin
            am_term = lfo_mod;                 // deep am
        end else begin
            am_term = {2'd0, lfo_mod[6:2]};    // shallow am, quarter depth
        end
    end

    assign mix_sum = {1'b0, level} + {3'd0, tl, 2'b00} + {4'd0, am_term};
    assign eg_out  = mix_sum[10] ? EG_SILENT : mix_sum[9:0];

endmodule

// ==== rtl/envelope_gen.sv ====
// envelope generator for time multiplexed FM operator slots, four stage pipeline
`timescale 1ns/1ps

module envelope_gen #(
    parameter int SLOTS = 18
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,      // one strobe per slot
    input  logic                 zero,     // slot 0 marker
    input  logic                 eg_stop,
    input  eg_pkg::eg_slot_cfg_t cfg,
    output eg_pkg::eg_level_t    eg_out,
    output logic                 pg_rst
);

    import eg_pkg::*;

    logic [EG_CNT_W-1:0] eg_cnt;

    // stage I, straight from the delay lines and cfg
    logic [1:0]   phase_dly;
    logic         key_last;
    eg_level_t    level_i;
    eg_phase_e    phase_next_i;
    logic [3:0]   base_rate_i;
    logic         pg_rst_i;

    // stage II
    eg_slot_cfg_t cfg_ii;
    eg_level_t    level_ii;
    logic [3:0]   base_rate_ii;
    logic         attack_ii;
    logic         pg_rst_ii;
    eg_step_t     step_info_ii;

    // stage III
    eg_slot_cfg_t cfg_iii;
    eg_level_t    level_iii;
    eg_step_t     step_iii;
    eg_level_t    level_next_iii;

    // stage IV
    eg_slot_cfg_t cfg_iv;
    eg_level_t    level_iv;     // also feeds the level loop
    eg_level_t    eg_out_iv;

    eg_frame_counter u_frame_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .zero    (zero),
        .eg_stop (eg_stop),
        .eg_cnt  (eg_cnt)
    );

    ////////////////////////////////////////////////////////////
    // per slot state loops

    eg_slot_delay #(.WIDTH(2), .STAGES(SLOTS), .RST_VAL(EG_RELEASE)) u_phase_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .din   (phase_next_i),
        .dout  (phase_dly)
    );

    eg_slot_delay #(.WIDTH(1), .STAGES(SLOTS), .RST_VAL(1'b0)) u_key_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .din   (cfg.keyon),
        .dout  (key_last)
    );

    // three stage registers carry the rest of the frame
    eg_slot_delay #(.WIDTH(10), .STAGES(SLOTS-3), .RST_VAL(EG_SILENT)) u_level_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .din   (level_iv),
        .dout  (level_i)
    );

    ////////////////////////////////////////////////////////////
    // stage logic

    eg_phase_ctrl u_phase_ctrl (
        .cfg        (cfg),
        .key_last   (key_last),
        .phase_in   (eg_phase_e'(phase_dly)),
        .level_in   (level_i),
        .phase_next (phase_next_i),
        .base_rate  (base_rate_i),
        .pg_rst     (pg_rst_i)
    );

    eg_step_gen u_step_gen (
        .base_rate (base_rate_ii),
        .attack    (attack_ii),
        .arate_max (cfg_ii.arate == 4'hf),
        .keycode   (cfg_ii.keycode),
        .ks        (cfg_ii.ks),
        .eg_cnt    (eg_cnt),
        .step_info (step_info_ii)
    );

    eg_level_update u_level_update (
        .step_info (step_iii),
        .level_in  (level_iii),
        .level_out (level_next_iii)
    );

    eg_output_mix u_output_mix (
        .level   (level_iv),
        .tl      (cfg_iv.tl),
        .amsen   (cfg_iv.amsen),
        .ams     (cfg_iv.ams),
        .lfo_mod (cfg_iv.lfo_mod),
        .eg_out  (eg_out_iv)
    );

    ////////////////////////////////////////////////////////////
    // stage registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_ii     <= EG_SILENT;
            level_iii    <= EG_SILENT;
            level_iv     <= EG_SILENT;
            base_rate_ii <= 4'd0;
            attack_ii    <= 1'b0;
            pg_rst_ii    <= 1'b0;
            step_iii     <= '0;
            pg_rst       <= 1'b0;
            eg_out       <= EG_SILENT;
        end else if (cen) begin
            // I -> II
            level_ii     <= level_i;
            base_rate_ii <= base_rate_i;
            attack_ii    <= (phase_next_i == EG_ATTACK);
            pg_rst_ii    <= pg_rst_i;
            // II -> III
            level_iii    <= level_ii;
            step_iii     <= step_info_ii;
            pg_rst       <= pg_rst_ii;   // out with stage III
            // III -> IV
            level_iv     <= level_next_iii;
            // IV -> out
            eg_out       <= eg_out_iv;
        end
    end

    // configuration travels with its slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_ii  <= '0;
            cfg_iii <= '0;
            cfg_iv  <= '0;   // zero tl and no am, idle output stays silent
        end else if (cen) begin
            cfg_ii  <= cfg;
            cfg_iii <= cfg_ii;
            cfg_iv  <= cfg_iii;
        end
    end

endmodule

// ==== dv/envelope_gen_props.sv ====
// bound concurrent checks on the envelope generator top level
`timescale 1ns/1ps

module envelope_gen_props #(
    parameter int SLOTS = 18
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cen,
    input eg_pkg::eg_slot_cfg_t cfg,
    input eg_pkg::eg_level_t    eg_out,
    input logic                 pg_rst
);

    import eg_pkg::*;

    int   slot_pos;          // output slot position, wraps each frame
    logic pg_seen [SLOTS];   // pg_rst one frame ago, per position
    int   frame_cens;        // strobes since reset, saturates at SLOTS
    logic key_seen;          // any key on since reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_pos   <= 0;
            frame_cens <= 0;
            key_seen   <= 1'b0;
            for (int i = 0; i < SLOTS; i++) begin
                pg_seen[i] <= 1'b0;
            end
        end else if (cen) begin
            slot_pos          <= (slot_pos == SLOTS - 1) ? 0 : slot_pos + 1;
            pg_seen[slot_pos] <= pg_rst;
            if (frame_cens < SLOTS) begin
                frame_cens <= frame_cens + 1;
            end
            if (cfg.keyon) begin
                key_seen <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // properties

    a_pg_rst_after_reset: assert property (@(posedge clk) !rst_n |=> !pg_rst)
        else $error("pg_rst high right after reset");

    a_out_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        !cen |=> $stable(eg_out))
        else $error("eg_out moved without a slot strobe");

    // a key on edge cannot repeat in the next frame for the same slot
    a_pg_rst_once: assert property (@(posedge clk) disable iff (!rst_n)
        cen && pg_rst |-> !pg_seen[slot_pos])
        else $error("pg_rst high in two consecutive frames for one slot");

    a_silent_first_frame: assert property (@(posedge clk) disable iff (!rst_n)
        (frame_cens < SLOTS) && !key_seen |-> eg_out == EG_SILENT)
        else $error("eg_out not silent in first frame with keys off");

endmodule

// ==== dv/envelope_gen_tb.sv ====
// testbench for the envelope generator, per slot reference model and comparing process
`timescale 1ns/1ps

module envelope_gen_tb;

    import eg_pkg::*;

    localparam int SLOTS     = 18;
    localparam int F_RESET   = 4;
    localparam int F_ATTACK  = 40;
    localparam int F_DECAY   = 61;   // one key off frame first
    localparam int F_RELEASE = 30;
    localparam int F_STOP    = 31;
    localparam int F_MIX     = 22;   // key off, 20 mixed, drain
    localparam int TOTAL_FRAMES = F_RESET + F_ATTACK + F_DECAY + F_RELEASE + F_STOP + F_MIX;
    // worst case two clocks per slot with gaps, plus reset and margin
    localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * SLOTS * 40 + 5000;

    logic         clk;
    logic         rst_n;
    logic         cen;
    logic         zero;
    logic         eg_stop;
    eg_slot_cfg_t cfg;
    eg_level_t    eg_out;
    logic         pg_rst;

    eg_slot_cfg_t slot_cfg [SLOTS];   // what each slot presents
    logic         stop_level;
    logic         gap_on;

    // reference state, one frame old per slot
    eg_phase_e           ref_phase [SLOTS];
    int                  ref_level [SLOTS];
    logic                ref_key   [SLOTS];
    logic [EG_CNT_W-1:0] ref_cnt;
    eg_level_t           exp_out_q [$];
    logic                exp_pg_q  [$];

    // inputs as the DUT samples them on the next edge
    logic         cen_seen;
    logic         zero_seen;
    logic         stop_seen;
    eg_slot_cfg_t cfg_seen;
    int           slot_idx;

    int err_cnt;
    int check_cnt;
    int test_no;
    int err_mark;
    int check_mark;

    envelope_gen #(.SLOTS(SLOTS)) u_envelope_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .zero    (zero),
        .eg_stop (eg_stop),
        .cfg     (cfg),
        .eg_out  (eg_out),
        .pg_rst  (pg_rst)
    );

    bind envelope_gen envelope_gen_props #(.SLOTS(SLOTS)) u_props (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .cfg    (cfg),
        .eg_out (eg_out),
        .pg_rst (pg_rst)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 ns period

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic void model_slot(input eg_slot_cfg_t c, input int s,
                                       input logic zero_in, input logic stop_in);
        eg_phase_e ph;
        int        lvl;
        int        base;
        int        rate;
        int        per_exp;
        int        inc;
        int        am;
        int        total;
        bit        on_edge;
        bit        off_edge;
        bit        stepped;
        if (zero_in && !stop_in) begin
            ref_cnt = ref_cnt + 1'b1;   // frame tick on slot 0
        end
        lvl      = ref_level[s];
        ph       = ref_phase[s];
        on_edge  = c.keyon && !ref_key[s];
        off_edge = !c.keyon && ref_key[s];
        if (on_edge) ph = EG_ATTACK;
        else if (off_edge) ph = EG_RELEASE;
        else if (ph == EG_ATTACK && lvl == 0) ph = EG_DECAY;
        else if (ph == EG_DECAY && lvl >= int'(c.sl) * 32) begin
            ph = c.en_sus ? EG_SUSTAIN : EG_RELEASE;
        end
        case (ph)
            EG_ATTACK:  base = c.arate;
            EG_DECAY:   base = c.drate;
            EG_SUSTAIN: base = 0;
            default:    base = c.rrate;
        endcase
        rate = 0;
        if (base != 0) begin
            rate = 4 * base + (c.ks ? int'(c.keycode) : int'(c.keycode) / 4);
            if (rate > 63) rate = 63;
        end
        per_exp = (11 - rate / 4 < 0) ? 0 : 11 - rate / 4;
        stepped = (rate != 0) && (int'(ref_cnt) % (1 << per_exp) == 0);
        inc     = (rate / 4 > 11) ? (1 << (rate / 4 - 11)) : 1;
        if (ph == EG_ATTACK && c.arate == 4'd15) begin
            lvl = 0;   // instant attack
        end else if (stepped && ph == EG_ATTACK) begin
            lvl = lvl - inc * (lvl / 8 + 1);
            if (lvl < 0) lvl = 0;
        end else if (stepped) begin
            lvl = (lvl + inc > 1023) ? 1023 : lvl + inc;
        end
        am    = !c.amsen ? 0 : (c.ams ? int'(c.lfo_mod) : int'(c.lfo_mod) / 4);
        total = lvl + 4 * int'(c.tl) + am;
        ref_level[s] = lvl;
        ref_phase[s] = ph;
        ref_key[s]   = c.keyon;
        exp_out_q.push_back(eg_level_t'((total > 1023) ? 1023 : total));
        exp_pg_q.push_back(on_edge);
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and comparison

    task automatic check_level(input string name, input eg_level_t got, input eg_level_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // mid cycle, outputs settled after the edge that sampled cfg
    always @(negedge clk) begin : compare
        eg_level_t exp_lvl;
        logic      exp_pg;
        if (rst_n && cen_seen) begin
            slot_idx = zero_seen ? 0 : slot_idx + 1;
            model_slot(cfg_seen, slot_idx, zero_seen, stop_seen);
            if (exp_pg_q.size() > 1) begin
                exp_pg = exp_pg_q.pop_front();   // two strobes of latency
                check_flag("pg_rst", pg_rst, exp_pg);
            end
            if (exp_out_q.size() > 3) begin
                exp_lvl = exp_out_q.pop_front(); // four strobes of latency
                check_level("eg_out", eg_out, exp_lvl);
            end
        end
        cen_seen  = cen;
        zero_seen = zero;
        stop_seen = eg_stop;
        cfg_seen  = cfg;
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    function automatic eg_slot_cfg_t rand_cfg();
        eg_slot_cfg_t c;
        logic [63:0]  bits;
        bits    = {$urandom(), $urandom()};
        c       = bits[$bits(eg_slot_cfg_t)-1:0];
        c.spare = 1'b0;
        return c;
    endfunction

    task automatic run_frames(input int n);
        for (int f = 0; f < n; f++) begin
            for (int s = 0; s < SLOTS; s++) begin
                if (gap_on && $urandom_range(0, 1) == 1) begin
                    @(posedge clk);
                    cen <= 1'b0;   // idle cycle between strobes
                end
                @(posedge clk);
                cen     <= 1'b1;
                zero    <= (s == 0);
                eg_stop <= stop_level;
                cfg     <= slot_cfg[s];
            end
        end
        @(posedge clk);
        cen  <= 1'b0;
        zero <= 1'b0;
    endtask

    task automatic keys_off_frame();
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s].keyon = 1'b0;
        end
        run_frames(1);
    endtask

    task automatic start_test();
        test_no++;
        err_mark   = err_cnt;
        check_mark = check_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %-14s %0d checks, %0d errors", test_no, name,
                 check_cnt - check_mark, err_cnt - err_mark);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the run did not finish in time", $time);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        eg_slot_cfg_t mix;
        void'($urandom(32'h3e39_7b62));
        rst_n      = 1'b0;
        cen        = 1'b0;
        zero       = 1'b0;
        eg_stop    = 1'b0;
        cfg        = '0;
        stop_level = 1'b0;
        gap_on     = 1'b0;
        err_cnt    = 0;
        check_cnt  = 0;
        test_no    = 0;
        cen_seen   = 1'b0;
        slot_idx   = 0;
        ref_cnt    = '0;
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s]  = '0;
            ref_phase[s] = EG_RELEASE;
            ref_level[s] = 1023;
            ref_key[s]   = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test();   // keys off, random tl still saturates
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s]       = rand_cfg();
            slot_cfg[s].keyon = 1'b0;
        end
        run_frames(F_RESET);
        end_test("reset state");

        start_test();   // instant and slow attacks, last third stays off
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s]       = rand_cfg();
            slot_cfg[s].keyon = (s < 12);
            slot_cfg[s].arate = (s < 6) ? 4'd15 : 4'($urandom_range(6, 14));
        end
        run_frames(F_ATTACK);
        end_test("key on attack");

        start_test();   // odd slots key scaled, even slots percussive
        keys_off_frame();
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s]        = rand_cfg();
            slot_cfg[s].keyon  = 1'b1;
            slot_cfg[s].arate  = 4'd15;
            slot_cfg[s].drate  = 4'($urandom_range(12, 15));
            slot_cfg[s].rrate  = 4'($urandom_range(12, 15));
            slot_cfg[s].sl     = 4'($urandom_range(0, 3));
            slot_cfg[s].en_sus = s[0];
            slot_cfg[s].ks     = s[0];
        end
        run_frames(F_DECAY - 1);
        end_test("decay sustain");

        start_test();   // every fourth slot has release rate 0
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s].keyon = 1'b0;
            slot_cfg[s].rrate = (s % 4 == 0) ? 4'd0 : 4'($urandom_range(10, 15));
        end
        run_frames(F_RELEASE);
        end_test("key off");

        start_test();   // slow attacks with a frozen counter and strobe gaps
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s]       = rand_cfg();
            slot_cfg[s].keyon = 1'b1;
            slot_cfg[s].arate = 4'($urandom_range(9, 14));
            slot_cfg[s].drate = 4'd13;
            slot_cfg[s].sl    = 4'd8;
        end
        gap_on = 1'b1;
        run_frames(1);
        stop_level = 1'b1;
        run_frames(10);
        stop_level = 1'b0;
        run_frames(F_STOP - 11);
        gap_on = 1'b0;
        end_test("stop and gaps");

        start_test();   // even slots sustain at 0, odd slots fall to silence
        keys_off_frame();
        for (int s = 0; s < SLOTS; s++) begin
            slot_cfg[s]        = rand_cfg();
            slot_cfg[s].keyon  = 1'b1;
            slot_cfg[s].arate  = 4'd15;
            slot_cfg[s].drate  = s[0] ? 4'd15 : 4'd0;
            slot_cfg[s].rrate  = 4'd15;
            slot_cfg[s].sl     = s[0] ? 4'($urandom_range(0, 15)) : 4'd0;
            slot_cfg[s].en_sus = ~s[0];
        end
        for (int f = 0; f < F_MIX - 2; f++) begin
            for (int s = 0; s < SLOTS; s++) begin
                mix                 = rand_cfg();
                slot_cfg[s].tl      = mix.tl;
                slot_cfg[s].amsen   = mix.amsen;
                slot_cfg[s].ams     = mix.ams;
                slot_cfg[s].lfo_mod = mix.lfo_mod;
            end
            run_frames(1);
        end
        run_frames(1);   // drain the pipeline
        end_test("output mix");

        $display("summary %0d tests, %0d checks, %0d errors", test_no, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/eg_pkg.sv
rtl/eg_frame_counter.sv
rtl/eg_slot_delay.sv
rtl/eg_phase_ctrl.sv
rtl/eg_step_gen.sv
rtl/eg_level_update.sv
rtl/eg_output_mix.sv
rtl/envelope_gen.sv
dv/envelope_gen_props.sv
dv/envelope_gen_tb.sv
